// File: sys_io_top.f
hdl/sys_cmd_pkg.sv
hdl/sys_audio_pkg.sv
hdl/audio_deglitch.sv
hdl/audio_mixer.sv
hdl/sync_polarity_fix.sv
hdl/hps_ctrl_regs.sv
hdl/sys_io_top.sv
tb/tb_sys_io_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile the sys_io_top testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_sys_io_top -f sys_io_top.f \
    && ./obj_dir/Vtb_sys_io_top > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q 'All tests passed!' sim.log 2>/dev/null \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: tb/tb_sys_io_top.sv
// Testbench with clock, LCG, register and mixer reference models, checker task and test sequence

`timescale 1ns/10ps

module tb_sys_io_top;

    import sys_cmd_pkg::*;
    import sys_audio_pkg::*;

    localparam int SYNC_PERIOD = 48;
    localparam int SYNC_SHORT  = 8;
    // Deglitch, pipeline and the pre value exchange all fit well inside this
    localparam int SETTLE_CYC  = 16;
    localparam int ACK_TIMEOUT = 20;

    logic                clk_sys;
    logic                resetd;
    logic                i_io_clk;
    logic                i_io_uio;
    logic [HOST_W-1:0]   i_io_din;
    logic                o_io_ack;
    logic                o_dvi_mode;
    logic                o_audio_96k;
    logic                o_ypbpr_en;
    logic                o_csync;
    logic                o_vga_scaler;
    logic                i_led_user;
    logic [1:0]          i_led_power;
    logic [1:0]          i_led_disk;
    logic [7:0]          o_led;
    logic                o_led_power_on;
    logic                o_led_disk_on;
    logic                o_led_user_on;
    logic                i_hs;
    logic                i_vs;
    logic                o_hs;
    logic                o_vs;
    logic [SAMPLE_W-1:0] i_core_l;
    logic [SAMPLE_W-1:0] i_core_r;
    logic [SAMPLE_W-1:0] i_linux_l;
    logic [SAMPLE_W-1:0] i_linux_r;
    logic                i_audio_signed;
    mix_mode_e           i_audio_mix;
    logic [SAMPLE_W-1:0] o_audio_l;
    logic [SAMPLE_W-1:0] o_audio_r;

    // Expected register contents
    cmd_data_u           exp_cfg;
    cmd_data_u           exp_led;
    logic [ATT_W-1:0]    exp_att;
    logic [31:0]         lcg_state = 32'd32;
    int                  fail_count = 0;

    sys_io_top #(.SYNC_CNT_W(12), .STABLE_DEPTH(2)) uut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // Free running sync with hs active low and vs active high
    initial begin
        i_hs <= 1'b0;
        i_vs <= 1'b0;
        forever begin
            for (int p = 0; p < SYNC_PERIOD; p++) begin
                @(posedge clk_sys);
                i_hs <= (p >= SYNC_SHORT);
                i_vs <= (p < SYNC_SHORT);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference models
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [7:0] core_led_ref(input logic user, input logic [1:0] pwr,
                                                input logic [1:0] dsk);
        logic [7:0] c;
        c    = 8'h00;
        c[0] = user;
        c[2] = (dsk == 2'b01) || (dsk == 2'b10);
        c[4] = (pwr == 2'b10);
        return c;
    endfunction

    function automatic logic [7:0] led_ref(input logic [7:0] ovr, input logic [7:0] st,
                                           input logic [7:0] core);
        logic [7:0] r;
        for (int b = 0; b < 8; b++) begin
            r[b] = ovr[b] ? st[b] : core[b];
        end
        return r;
    endfunction

    // Core plus Linux before the blend
    function automatic int chan_sum(input logic [15:0] core, input logic [15:0] linux,
                                    input logic sgn);
        int c;
        if (sgn) begin
            c = int'($signed(core));
        end else begin
            c = int'(core) >>> 1;
        end
        return c + int'($signed(linux));
    endfunction

    function automatic logic [15:0] mix_ref(input int own, input int other_sum,
                                            input mix_mode_e mode, input logic [4:0] att);
        int other;
        int blend;
        int v;
        // Pre value of the other channel is its sum halved
        other = other_sum >>> 1;
        case (mode)
            MIX_OFF: blend = own;
            MIX_25:  blend = own - (own >>> 3) + (other >>> 2);
            MIX_50:  blend = own - (own >>> 2) + (other >>> 1);
            default: blend = (own >>> 1) + other;
        endcase
        v = att[4] ? 0 : (blend >>> att[3:0]);
        if (v > 32767) begin
            v = 32767;
        end
        if (v < -32768) begin
            v = -32768;
        end
        return v[15:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // Checking and host port tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] expect_v,
                            input string what);
        if (got !== expect_v) begin
            fail_count++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, expect_v);
            stop_with_failure();
        end
    endtask

    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_sys);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                $display("Timeout: io_ack never went to %0d after io_clk changed", level);
                stop_with_failure();
            end
        end while (o_io_ack !== level);
    endtask

    task automatic host_strobe(input logic [15:0] word);
        int lat;
        @(posedge clk_sys);
        i_io_din <= word;
        @(posedge clk_sys);
        i_io_clk <= 1'b1;
        wait_ack(1'b1, lat);
        // First negedge falls in the drive cycle
        check_eq(32'(lat - 1), 32'd3, "io_ack latency");
        @(posedge clk_sys);
        i_io_clk <= 1'b0;
        wait_ack(1'b0, lat);
    endtask

    task automatic send_frame(input logic [7:0] cmd, input logic [15:0] data);
        @(posedge clk_sys);
        i_io_uio <= 1'b1;
        host_strobe({8'h00, cmd});
        host_strobe(data);
        @(posedge clk_sys);
        i_io_uio <= 1'b0;
        case (cmd)
            CMD_CFG: exp_cfg = data;
            CMD_LED: exp_led = data;
            CMD_VOL: exp_att = data[ATT_W-1:0];
            default: ;
        endcase
    endtask

    task automatic check_regs(input string tag);
        logic [7:0] core;
        @(negedge clk_sys);
        core = core_led_ref(i_led_user, i_led_power, i_led_disk);
        check_eq(32'(o_dvi_mode), 32'(exp_cfg.cfg.dvi_mode), {tag, " dvi_mode"});
        check_eq(32'(o_audio_96k), 32'(exp_cfg.cfg.audio_96k), {tag, " audio_96k"});
        check_eq(32'(o_ypbpr_en), 32'(exp_cfg.cfg.ypbpr_en), {tag, " ypbpr_en"});
        check_eq(32'(o_csync), 32'(exp_cfg.cfg.csync), {tag, " csync"});
        check_eq(32'(o_vga_scaler), 32'(exp_cfg.cfg.vga_scaler), {tag, " vga_scaler"});
        check_eq(32'(o_led_user_on), 32'(core[0]), {tag, " user led"});
        check_eq(32'(o_led_disk_on), 32'(core[2]), {tag, " disk led"});
        check_eq(32'(o_led_power_on), 32'(core[4]), {tag, " power led"});
        check_eq(32'(o_led), 32'(led_ref(exp_led.led.overtake, exp_led.led.state, core)),
                 {tag, " o_led"});
    endtask

    task automatic drive_audio(input logic [15:0] cl, input logic [15:0] cr,
                               input logic [15:0] ll, input logic [15:0] lr,
                               input logic sgn, input mix_mode_e mode);
        int sl;
        int sr;
        @(posedge clk_sys);
        i_core_l       <= cl;
        i_core_r       <= cr;
        i_linux_l      <= ll;
        i_linux_r      <= lr;
        i_audio_signed <= sgn;
        i_audio_mix    <= mode;
        repeat (SETTLE_CYC) @(posedge clk_sys);
        @(negedge clk_sys);
        sl = chan_sum(cl, ll, sgn);
        sr = chan_sum(cr, lr, sgn);
        check_eq(32'(o_audio_l), 32'(mix_ref(sl, sr, mode, exp_att)),
                 $sformatf("o_audio_l sgn=%0d mix=%0d att=%h", sgn, mode, exp_att));
        check_eq(32'(o_audio_r), 32'(mix_ref(sr, sl, mode, exp_att)),
                 $sformatf("o_audio_r sgn=%0d mix=%0d att=%h", sgn, mode, exp_att));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [15:0] r;
        logic [15:0] cl;
        logic [15:0] cr;
        logic [15:0] ll;
        logic [15:0] lr;

        i_io_clk       <= 1'b0;
        i_io_uio       <= 1'b0;
        i_io_din       <= '0;
        i_led_user     <= 1'b0;
        i_led_power    <= 2'b00;
        i_led_disk     <= 2'b00;
        i_core_l       <= '0;
        i_core_r       <= '0;
        i_linux_l      <= '0;
        i_linux_r      <= '0;
        i_audio_signed <= 1'b0;
        i_audio_mix    <= MIX_OFF;
        resetd         <= 1'b1;
        exp_cfg = '0;
        exp_led = '0;
        exp_att = '0;
        repeat (5) @(posedge clk_sys);
        resetd <= 1'b0;

        // Reset defaults
        check_regs("reset");
        check_eq(32'(o_io_ack), 32'd0, "io_ack after reset");

        // Sync polarity settles after two periods
        repeat (3 * SYNC_PERIOD) @(posedge clk_sys);
        for (int k = 0; k < 2 * SYNC_PERIOD; k++) begin
            @(negedge clk_sys);
            check_eq(32'(o_hs), i_hs ? 32'd0 : 32'd1, "o_hs inverted");
            check_eq(32'(o_vs), 32'(i_vs), "o_vs unchanged");
        end

        // Configuration writes followed by ignored words
        repeat (6) begin
            send_frame(CMD_CFG, lcg_next());
            check_regs("cfg write");
        end
        // A whole frame with uio held low must not write
        host_strobe({8'h00, CMD_CFG});
        host_strobe(~exp_cfg);
        check_regs("strobe with uio low");
        send_frame(8'h33, lcg_next());
        check_regs("unknown command");

        // LED overtake with random core requests
        repeat (8) begin
            r = lcg_next();
            @(posedge clk_sys);
            i_led_user  <= r[0];
            i_led_power <= r[2:1];
            i_led_disk  <= r[4:3];
            send_frame(CMD_LED, lcg_next());
            check_regs("led overtake");
        end
        send_frame(CMD_LED, 16'h0000);
        for (int k = 0; k < 32; k++) begin
            @(posedge clk_sys);
            i_led_user  <= k[0];
            i_led_power <= k[2:1];
            i_led_disk  <= k[4:3];
            check_regs("core led");
        end

        // Every signedness and mix mode at full volume
        for (int s = 0; s < 2; s++) begin
            for (int m = 0; m < 4; m++) begin
                repeat (3) begin
                    drive_audio(lcg_next(), lcg_next(), lcg_next(), lcg_next(), s[0],
                                mix_mode_e'(m));
                end
            end
        end

        // Attenuation shifts
        cl = lcg_next();
        cr = lcg_next();
        ll = lcg_next();
        lr = lcg_next();
        for (int k = 0; k < 4; k++) begin
            send_frame(CMD_VOL, 16'(k * 4 + 3));
            drive_audio(cl, cr, ll, lr, 1'b1, MIX_50);
        end

        // Mute bit
        send_frame(CMD_VOL, 16'h0010 | (lcg_next() & 16'h000F));
        drive_audio(cl, cr, ll, lr, 1'b1, MIX_MONO);
        check_eq(32'(o_audio_l), 32'd0, "muted o_audio_l");
        check_eq(32'(o_audio_r), 32'd0, "muted o_audio_r");

        // Full scale drives both clamp limits
        send_frame(CMD_VOL, 16'h0000);
        drive_audio(16'h7FFF, 16'h8000, 16'h7FFF, 16'h8000, 1'b1, MIX_OFF);
        check_eq(32'(o_audio_l), 32'h7FFF, "positive clamp");
        check_eq(32'(o_audio_r), 32'h8000, "negative clamp");

        if (fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// File: hdl/sys_io_top.sv
// Top level: host control registers, sync polarity fixers and the stereo audio mixers

`timescale 1ns/10ps

module sys_io_top #(
    parameter int SYNC_CNT_W   = 12,
    parameter int STABLE_DEPTH = 2
) (
    input  logic                               clk_sys,
    input  logic                               resetd,

    // Host command port
    input  logic                               i_io_clk,
    input  logic                               i_io_uio,
    input  logic [sys_cmd_pkg::HOST_W-1:0]     i_io_din,
    output logic                               o_io_ack,

    // Configuration
    output logic                               o_dvi_mode,
    output logic                               o_audio_96k,
    output logic                               o_ypbpr_en,
    output logic                               o_csync,
    output logic                               o_vga_scaler,

    // LEDs
    input  logic                               i_led_user,
    input  logic [1:0]                         i_led_power,
    input  logic [1:0]                         i_led_disk,
    output logic [7:0]                         o_led,
    output logic                               o_led_power_on,
    output logic                               o_led_disk_on,
    output logic                               o_led_user_on,

    // Video sync
    input  logic                               i_hs,
    input  logic                               i_vs,
    output logic                               o_hs,
    output logic                               o_vs,

    // Audio
    input  logic [sys_audio_pkg::SAMPLE_W-1:0] i_core_l,
    input  logic [sys_audio_pkg::SAMPLE_W-1:0] i_core_r,
    input  logic [sys_audio_pkg::SAMPLE_W-1:0] i_linux_l,
    input  logic [sys_audio_pkg::SAMPLE_W-1:0] i_linux_r,
    input  logic                               i_audio_signed,
    input  sys_audio_pkg::mix_mode_e           i_audio_mix,
    output logic [sys_audio_pkg::SAMPLE_W-1:0] o_audio_l,
    output logic [sys_audio_pkg::SAMPLE_W-1:0] o_audio_r
);

    import sys_audio_pkg::*;

    logic [ATT_W-1:0]    vol_att;
    logic [SAMPLE_W-1:0] pre_l;
    logic [SAMPLE_W-1:0] pre_r;

    hps_ctrl_regs u_ctrl (
        .clk_sys        (clk_sys),
        .resetd         (resetd),
        .i_io_clk       (i_io_clk),
        .i_io_uio       (i_io_uio),
        .i_io_din       (i_io_din),
        .o_io_ack       (o_io_ack),
        .i_led_user     (i_led_user),
        .i_led_power    (i_led_power),
        .i_led_disk     (i_led_disk),
        .o_dvi_mode     (o_dvi_mode),
        .o_audio_96k    (o_audio_96k),
        .o_ypbpr_en     (o_ypbpr_en),
        .o_csync        (o_csync),
        .o_vga_scaler   (o_vga_scaler),
        .o_vol_att      (vol_att),
        .o_led          (o_led),
        .o_led_power_on (o_led_power_on),
        .o_led_disk_on  (o_led_disk_on),
        .o_led_user_on  (o_led_user_on)
    );

    sync_polarity_fix #(.SYNC_CNT_W(SYNC_CNT_W)) u_sync_h (
        .clk_sys (clk_sys),
        .resetd  (resetd),
        .i_sync  (i_hs),
        .o_sync  (o_hs)
    );

    sync_polarity_fix #(.SYNC_CNT_W(SYNC_CNT_W)) u_sync_v (
        .clk_sys (clk_sys),
        .resetd  (resetd),
        .i_sync  (i_vs),
        .o_sync  (o_vs)
    );

    // Channels trade pre-mix values for the stereo blend
    audio_mixer #(.STABLE_DEPTH(STABLE_DEPTH)) u_mix_l (
        .clk_sys     (clk_sys),
        .resetd      (resetd),
        .i_core      (i_core_l),
        .i_linux     (i_linux_l),
        .i_pre_other (pre_r),
        .i_signed    (i_audio_signed),
        .i_mix       (i_audio_mix),
        .i_att       (vol_att),
        .o_pre       (pre_l),
        .o_out       (o_audio_l)
    );

    audio_mixer #(.STABLE_DEPTH(STABLE_DEPTH)) u_mix_r (
        .clk_sys     (clk_sys),
        .resetd      (resetd),
        .i_core      (i_core_r),
        .i_linux     (i_linux_r),
        .i_pre_other (pre_l),
        .i_signed    (i_audio_signed),
        .i_mix       (i_audio_mix),
        .i_att       (vol_att),
        .o_pre       (pre_r),
        .o_out       (o_audio_r)
    );

endmodule

// File: hdl/hps_ctrl_regs.sv
// Host command framing, configuration and volume registers, board LED combiner

`timescale 1ns/10ps

module hps_ctrl_regs (
    input  logic                              clk_sys,
    input  logic                              resetd,

    // Host command port
    input  logic                              i_io_clk,
    input  logic                              i_io_uio,
    input  logic [sys_cmd_pkg::HOST_W-1:0]    i_io_din,
    output logic                              o_io_ack,

    // Core LED requests
    input  logic                              i_led_user,
    input  logic [1:0]                        i_led_power,
    input  logic [1:0]                        i_led_disk,

    // Configuration bits
    output logic                              o_dvi_mode,
    output logic                              o_audio_96k,
    output logic                              o_ypbpr_en,
    output logic                              o_csync,
    output logic                              o_vga_scaler,
    output logic [sys_audio_pkg::ATT_W-1:0]   o_vol_att,

    // LED drive
    output logic [7:0]                        o_led,
    output logic                              o_led_power_on,
    output logic                              o_led_disk_on,
    output logic                              o_led_user_on
);

    import sys_cmd_pkg::*;
    import sys_audio_pkg::*;

    logic             io_clk_s1;
    logic             io_clk_s2;
    logic             io_strobe;
    logic             has_cmd;
    logic [CMD_W-1:0] cmd_q;
    cmd_data_u        din_u;
    cmd_data_u        cfg_q;
    cmd_data_u        led_q;
    logic [7:0]       core_led;

    ////////////////////////////////////////////////////////////
    // Strobe recovery
    ////////////////////////////////////////////////////////////

    // Two flops of synchronizer, the ack flop doubles as edge history
    always_ff @(posedge clk_sys) begin
        if (resetd) begin
            io_clk_s1 <= 1'b0;
            io_clk_s2 <= 1'b0;
            o_io_ack  <= 1'b0;
        end else begin
            io_clk_s1 <= i_io_clk;
            io_clk_s2 <= io_clk_s1;
            o_io_ack  <= io_clk_s2;
        end
    end

    assign io_strobe = io_clk_s2 & ~o_io_ack;
    assign din_u     = i_io_din;

    ////////////////////////////////////////////////////////////
    // Command framing and register writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (resetd) begin
            has_cmd   <= 1'b0;
            cfg_q     <= '0;
            led_q     <= '0;
            o_vol_att <= '0;
        end else if (!i_io_uio) begin
            // Frame closed by host
            has_cmd <= 1'b0;
        end else if (io_strobe) begin
            if (!has_cmd) begin
                has_cmd <= 1'b1;
            end else begin
                case (cmd_q)
                    CMD_CFG: cfg_q     <= din_u;
                    CMD_LED: led_q     <= din_u;
                    CMD_VOL: o_vol_att <= i_io_din[ATT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // First word of a frame is the command
    always_ff @(posedge clk_sys) begin
        if (io_strobe && i_io_uio && !has_cmd) begin
            cmd_q <= i_io_din[CMD_W-1:0];
        end
    end

    assign o_dvi_mode   = cfg_q.cfg.dvi_mode;
    assign o_audio_96k  = cfg_q.cfg.audio_96k;
    assign o_ypbpr_en   = cfg_q.cfg.ypbpr_en;
    assign o_csync      = cfg_q.cfg.csync;
    assign o_vga_scaler = cfg_q.cfg.vga_scaler;

    ////////////////////////////////////////////////////////////
    // Board LEDs
    ////////////////////////////////////////////////////////////

    assign o_led_power_on = i_led_power[1] & ~i_led_power[0];
    // Bit 1 flips the sense of bit 0
    assign o_led_disk_on  = i_led_disk[1] ? ~i_led_disk[0] : i_led_disk[0];
    assign o_led_user_on  = i_led_user;

    assign core_led = {3'b000, o_led_power_on, 1'b0, o_led_disk_on, 1'b0, o_led_user_on};

    // Host overrides per bit
    assign o_led = (led_q.led.overtake & led_q.led.state) |
                   (~led_q.led.overtake & core_led);

    // Registers only move on a strobe that arrived inside a frame
    a_no_write_outside_frame : assert property (
        @(posedge clk_sys) disable iff (resetd)
        ((cfg_q != $past(cfg_q)) || (led_q != $past(led_q)) ||
         (o_vol_att != $past(o_vol_att))) |-> $past(i_io_uio)
    );

endmodule

// File: hdl/sync_polarity_fix.sv
// Sync phase measurement and polarity normalization to a short active pulse

`timescale 1ns/10ps

module sync_polarity_fix #(
    parameter int SYNC_CNT_W = 12
) (
    input  logic clk_sys,
    input  logic resetd,
    input  logic i_sync,
    output logic o_sync
);

    logic                  sync_s1;
    logic                  sync_s2;
    logic [SYNC_CNT_W-1:0] cnt_q;
    logic [SYNC_CNT_W-1:0] high_len;
    logic [SYNC_CNT_W-1:0] low_len;
    logic                  pol_q;

    always_ff @(posedge clk_sys) begin
        if (resetd) begin
            sync_s1  <= 1'b0;
            sync_s2  <= 1'b0;
            cnt_q    <= '0;
            high_len <= '0;
            low_len  <= '0;
            pol_q    <= 1'b0;
        end else begin
            sync_s1 <= i_sync;
            sync_s2 <= sync_s1;

            // Phase length restarts on every edge
            if (sync_s1 != sync_s2) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + SYNC_CNT_W'(1);
            end

            // Rising edge ends a low phase, falling edge a high one
            if (sync_s1 && !sync_s2) begin
                low_len <= cnt_q;
            end
            if (!sync_s1 && sync_s2) begin
                high_len <= cnt_q;
            end

            pol_q <= (high_len > low_len);
        end
    end

    // Invert when the high phase is the long one
    assign o_sync = i_sync ^ pol_q;

    // Phase must end before the counter runs out
    a_cnt_no_wrap : assert property (
        @(posedge clk_sys) disable iff (resetd)
        (cnt_q == '1) |-> (sync_s1 != sync_s2)
    );

endmodule

// File: hdl/audio_mixer.sv
// One audio channel: deglitch, core plus Linux sum, stereo blend, attenuation, clamp

`timescale 1ns/10ps

module audio_mixer #(
    parameter int STABLE_DEPTH = 2
) (
    input  logic                               clk_sys,
    input  logic                               resetd,
    input  logic [sys_audio_pkg::SAMPLE_W-1:0] i_core,
    input  logic [sys_audio_pkg::SAMPLE_W-1:0] i_linux,
    input  logic [sys_audio_pkg::SAMPLE_W-1:0] i_pre_other,
    input  logic                               i_signed,
    input  sys_audio_pkg::mix_mode_e           i_mix,
    input  logic [sys_audio_pkg::ATT_W-1:0]    i_att,
    output logic [sys_audio_pkg::SAMPLE_W-1:0] o_pre,
    output logic [sys_audio_pkg::SAMPLE_W-1:0] o_out
);

    import sys_audio_pkg::*;

    logic        [SAMPLE_W-1:0] core_held;
    logic signed [SAMPLE_W:0]   linux_x;
    logic signed [SAMPLE_W:0]   other_x;
    logic signed [SAMPLE_W:0]   a1_q;
    logic signed [SAMPLE_W:0]   a2_q;
    logic signed [SAMPLE_W:0]   a3_q;
    logic signed [SAMPLE_W:0]   a4_q;
    logic [ATT_SHIFT_W-1:0]     att_shift;

    audio_deglitch #(
        .STABLE_DEPTH (STABLE_DEPTH)
    ) u_deglitch (
        .clk_sys  (clk_sys),
        .resetd   (resetd),
        .i_sample (i_core),
        .o_sample (core_held)
    );

    assign linux_x   = {i_linux[SAMPLE_W-1], i_linux};
    assign other_x   = {i_pre_other[SAMPLE_W-1], i_pre_other};
    assign att_shift = i_att[ATT_SHIFT_W-1:0];

    ////////////////////////////////////////////////////////////
    // Sum and blend, stages 1 to 3
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        // Unsigned core audio is halved into the positive range
        if (i_signed) begin
            a1_q <= {core_held[SAMPLE_W-1], core_held};
        end else begin
            a1_q <= {2'b00, core_held[SAMPLE_W-1:1]};
        end

        a2_q <= a1_q + linux_x;

        case (i_mix)
            MIX_OFF:  a3_q <= a2_q;
            MIX_25:   a3_q <= a2_q - (a2_q >>> 3) + (other_x >>> 2);
            MIX_50:   a3_q <= a2_q - (a2_q >>> 2) + (other_x >>> 1);
            MIX_MONO: a3_q <= (a2_q >>> 1) + other_x;
            default:  a3_q <= a2_q;
        endcase

        // Volume
        if (i_att[ATT_MUTE_BIT]) begin
            a4_q <= '0;
        end else begin
            a4_q <= a3_q >>> att_shift;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs, pre value for the other channel and clamp
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (resetd) begin
            o_pre <= '0;
            o_out <= '0;
        end else begin
            o_pre <= a2_q[SAMPLE_W:1];
            // Top two bits differ on overflow
            if (a4_q[SAMPLE_W] != a4_q[SAMPLE_W-1]) begin
                o_out <= {a4_q[SAMPLE_W], {(SAMPLE_W-1){~a4_q[SAMPLE_W]}}};
            end else begin
                o_out <= a4_q[SAMPLE_W-1:0];
            end
        end
    end

    // Mute held through the pipeline depth silences the output
    a_mute_clears_out : assert property (
        @(posedge clk_sys) disable iff (resetd)
        i_att[ATT_MUTE_BIT] [*5] |=> (o_out == '0)
    );

endmodule

// File: hdl/audio_deglitch.sv
// Core sample stability filter, holds the last sample seen steady for several cycles

`timescale 1ns/10ps

module audio_deglitch #(
    parameter int STABLE_DEPTH = 2
) (
    input  logic                               clk_sys,
    input  logic                               resetd,
    input  logic [sys_audio_pkg::SAMPLE_W-1:0] i_sample,
    output logic [sys_audio_pkg::SAMPLE_W-1:0] o_sample
);

    import sys_audio_pkg::*;

    logic [SAMPLE_W-1:0] dly_q [STABLE_DEPTH+1];
    logic                steady;

    // Delay line, stage 0 only retimes the input
    always_ff @(posedge clk_sys) begin
        dly_q[0] <= i_sample;
        for (int k = 1; k <= STABLE_DEPTH; k++) begin
            dly_q[k] <= dly_q[k-1];
        end
    end

    always_comb begin
        steady = 1'b1;
        for (int k = 2; k <= STABLE_DEPTH; k++) begin
            if (dly_q[k] != dly_q[1]) begin
                steady = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (resetd) begin
            o_sample <= '0;
        end else if (steady) begin
            o_sample <= dly_q[1];
        end
    end

endmodule

// File: hdl/sys_audio_pkg.sv
// Audio sample width, attenuation field layout and stereo mix mode codes

package sys_audio_pkg;

    // Signed PCM sample
    localparam int SAMPLE_W = 16;

    ////////////////////////////////////////////////////////////
    // Attenuation control
    ////////////////////////////////////////////////////////////

    // Top bit mutes, the rest is a right shift
    localparam int ATT_W        = 5;
    localparam int ATT_MUTE_BIT = ATT_W - 1;
    localparam int ATT_SHIFT_W  = ATT_W - 1;

    ////////////////////////////////////////////////////////////
    // Cross-channel blend
    ////////////////////////////////////////////////////////////

    // Amount of the opposite channel folded in
    typedef enum logic [1:0] {
        MIX_OFF  = 2'd0,
        MIX_25   = 2'd1,
        MIX_50   = 2'd2,
        MIX_MONO = 2'd3
    } mix_mode_e;

endpackage

// File: hdl/sys_cmd_pkg.sv
// Host command port width, command codes and the two views of a command data word

package sys_cmd_pkg;

    // Host data word and command byte
    localparam int HOST_W = 16;
    localparam int CMD_W  = 8;

    ////////////////////////////////////////////////////////////
    // Command codes
    ////////////////////////////////////////////////////////////

    // System configuration word
    localparam logic [CMD_W-1:0] CMD_CFG = 8'h01;
    // Board LED overtake and state
    localparam logic [CMD_W-1:0] CMD_LED = 8'h25;
    // Volume attenuation
    localparam logic [CMD_W-1:0] CMD_VOL = 8'h26;

    ////////////////////////////////////////////////////////////
    // Data word views
    ////////////////////////////////////////////////////////////

    // Configuration view, bits 15..8 carry the HDMI mode fields elsewhere
    typedef struct packed {
        logic [7:0] rsvd_hi;
        logic       dvi_mode;
        logic       audio_96k;
        logic       ypbpr_en;
        logic       rsvd_4;
        logic       csync;
        logic       vga_scaler;
        logic [1:0] rsvd_lo;
    } cfg_view_t;

    // LED view, overtake mask in the high byte
    typedef struct packed {
        logic [7:0] overtake;
        logic [7:0] state;
    } led_view_t;

    // One host word, decoded by the command that precedes it
    typedef union packed {
        cfg_view_t cfg;
        led_view_t led;
    } cmd_data_u;

endpackage
